// File: ats21_consts.svh
// sizes, widths, instruction field positions and alarm hold length
`ifndef ATS21_CONSTS_SVH
`define ATS21_CONSTS_SVH

////////////////////
// bank sizes
`define ATS21_NUM_CLOCKS    16  // counters
`define ATS21_NUM_ALARMS    24  // alarms and countdown timers

////////////////////
// widths
`define ATS21_COUNT_W       16  // counter and alarm value
`define ATS21_CLOCK_SEL_W   4   // counter index
`define ATS21_ALARM_SEL_W   5   // alarm index, also the full sel field
`define ATS21_HALF_W        16  // one beat on a client bus
`define ATS21_OP_W          3   // opcode field
`define ATS21_FLAGS_W       4   // flags field

////////////////////
// bit positions inside the instruction fields
`define ATS21_FLAG_BIT      3   // flags, enable / repeat / upper rate bit
`define ATS21_RATE_LO_BIT   2   // flags, lower rate bit
`define ATS21_MODE_ACTIVE_BIT 4 // sel, device active (word bit 28)
`define ATS21_MODE_ALARM_BIT  3 // sel, alarm change allowed (word bit 27)
`define ATS21_MODE_CLOCK_BIT  1 // sel, clock change allowed (word bit 25)

// alarm output pulse
`define ATS21_HOLD_CYCLES   2
`define ATS21_HOLD_W        2   // hold counter, must fit HOLD_CYCLES

`endif

// File: ats21InstPkg.sv
// instruction word layout, opcode enum, client status enum, decode helpers
`default_nettype none
`include "ats21_consts.svh"

package ats21InstPkg;

  // 100 has no name, decodes as illegal
  typedef enum logic [`ATS21_OP_W-1:0] {
    nop         = 3'b000,
    setClock    = 3'b001,
    enableClock = 3'b010,
    setMode     = 3'b011,
    setAlarm    = 3'b101,
    setTimer    = 3'b110,
    enableAlarm = 3'b111
  } opcode_e;

  typedef struct packed {
    opcode_e                      opcode;    // 31..29
    logic [`ATS21_ALARM_SEL_W-1:0] sel;      // 28..24, counter index is the top four
    logic [`ATS21_FLAGS_W-1:0]     flags;    // 23..20
    logic [`ATS21_CLOCK_SEL_W-1:0] clockSel; // 19..16, counter an alarm watches
    logic [`ATS21_COUNT_W-1:0]     value;    // 15..0
  } instWord_t;

  typedef enum logic {nack = 1'b0, ack = 1'b1} status_e;

  // counter index sits in sel[4:1]
  function automatic logic [`ATS21_CLOCK_SEL_W-1:0] clockIndex(instWord_t inst);
    return inst.sel[`ATS21_ALARM_SEL_W-1 -: `ATS21_CLOCK_SEL_W];
  endfunction

  function automatic logic isAlarmOp(opcode_e op);
    return op inside {setAlarm, setTimer, enableAlarm};
  endfunction

endpackage

`default_nettype wire

// File: ats21StatePkg.sv
// counter and alarm write commands, rate enum, mode register
`default_nettype none
`include "ats21_consts.svh"

package ats21StatePkg;

  typedef enum logic [1:0] {
    full    = 2'b00,  // every clk_1x edge
    half    = 2'b01,  // every second edge
    quarter = 2'b10,  // every fourth edge
    stopped = 2'b11
  } rate_e;

  // one counter write
  typedef struct packed {
    logic                          valid;
    logic                          load;   // set-clock, else enable bit only
    logic [`ATS21_CLOCK_SEL_W-1:0] index;
    logic                          enable;
    rate_e                         rate;
    logic [`ATS21_COUNT_W-1:0]     count;
  } clockCmd_t;

  typedef enum logic [1:0] {
    setAlarm  = 2'd0,
    setTimer  = 2'd1,  // value is relative to the counter
    setEnable = 2'd2
  } alarmCmd_e;

  // one alarm write
  typedef struct packed {
    logic                          valid;
    alarmCmd_e                     kind;
    logic [`ATS21_ALARM_SEL_W-1:0] index;
    logic [`ATS21_CLOCK_SEL_W-1:0] clockSel;
    logic                          loop;   // repeat after firing
    logic                          enable;
    logic [`ATS21_COUNT_W-1:0]     value;
  } alarmCmd_t;

  typedef struct packed {
    logic active;
    logic clockAllowA;
    logic clockAllowB;
    logic alarmAllowA;
    logic alarmAllowB;
  } modeReg_t;

  // device comes up running, both clients allowed everything
  localparam modeReg_t modeReset = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1};

endpackage

`default_nettype wire

// File: ats21InstCapture.sv
// two-beat instruction capture for one client bus
`timescale 1ns/10ps
`default_nettype none
`include "ats21_consts.svh"

module ats21InstCapture (
  input  wire                      clk_1x,
  input  wire                      reset,
  input  wire                      req,
  input  wire [`ATS21_HALF_W-1:0]  ctrl,
  output ats21InstPkg::instWord_t  inst,
  output logic                     present
);

  logic                     pending;    // upper half held, lower half due now
  logic                     firstBeat;
  logic [`ATS21_HALF_W-1:0] upperHalf;

  ////////////////////
  // first beat
  // opcode rides in the top bits of the upper half
  assign firstBeat = req && !pending &&
                     (ctrl[`ATS21_HALF_W-1 -: `ATS21_OP_W] != ats21InstPkg::nop);

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      pending <= 1'b0;
    end else begin
      pending <= firstBeat;  // drops after one cycle, beat during it is lost
    end
  end

  // upper half payload
  always_ff @(posedge clk_1x) begin
    if (firstBeat) begin
      upperHalf <= ctrl;
    end
  end

  ////////////////////
  // second beat
  // lower half straight off the bus, req not looked at
  assign inst    = ats21InstPkg::instWord_t'({upperHalf, ctrl});
  assign present = pending;

endmodule

`default_nettype wire

// File: ats21Arbiter.sv
// two-client arbiter, conflict/range/permission checks, command and mode registers
`timescale 1ns/10ps
`default_nettype none
`include "ats21_consts.svh"

module ats21Arbiter (
  input  wire                                clk_1x,
  input  wire                                reset,
  input  wire ats21InstPkg::instWord_t       instA,
  input  wire                                presentA,
  input  wire ats21InstPkg::instWord_t       instB,
  input  wire                                presentB,
  output ats21StatePkg::clockCmd_t [1:0]     clockCmd,  // 0 is client A
  output ats21StatePkg::alarmCmd_t [1:0]     alarmCmd,
  output ats21StatePkg::modeReg_t            mode,
  output logic [1:0]                         stat
);

  ats21InstPkg::instWord_t [1:0] inst;
  ats21InstPkg::opcode_e   [1:0] op;      // nop when absent
  ats21StatePkg::alarmCmd_e [1:0] kind;
  logic [1:0] isClock;
  logic [1:0] isAlarm;
  logic [1:0] isMode;
  logic [1:0] legal;                      // opcode known, index in range
  logic [1:0] permitted;
  logic [1:0] clockAllow;
  logic [1:0] alarmAllow;
  logic [1:0] accept;
  logic       conflict;

  assign inst       = {instB, instA};
  assign clockAllow = {mode.clockAllowB, mode.clockAllowA};
  assign alarmAllow = {mode.alarmAllowB, mode.alarmAllowA};

  ////////////////////
  // per-client decode
  always_comb begin
    for (int c = 0; c < 2; c++) begin
      op[c] = (c == 0 ? presentA : presentB) ? inst[c].opcode : ats21InstPkg::nop;
      isClock[c] = (op[c] == ats21InstPkg::setClock) || (op[c] == ats21InstPkg::enableClock);
      isAlarm[c] = ats21InstPkg::isAlarmOp(op[c]);
      isMode[c]  = (op[c] == ats21InstPkg::setMode);
      // 100 and nop fall out of every group
      legal[c] = isClock[c] || isMode[c] ||
                 (isAlarm[c] && (inst[c].sel < `ATS21_NUM_ALARMS));
      permitted[c] = (isClock[c] && clockAllow[c]) ||
                     (isAlarm[c] && alarmAllow[c]) ||
                     isMode[c];             // mode writes need no permission
      case (op[c])
        ats21InstPkg::setTimer:    kind[c] = ats21StatePkg::setTimer;
        ats21InstPkg::enableAlarm: kind[c] = ats21StatePkg::setEnable;
        default:                   kind[c] = ats21StatePkg::setAlarm;
      endcase
    end
  end

  ////////////////////
  // cross-client checks
  always_comb begin
    conflict = (isClock[0] && isClock[1] &&
                (ats21InstPkg::clockIndex(inst[0]) == ats21InstPkg::clockIndex(inst[1]))) ||
               (isAlarm[0] && isAlarm[1] && (inst[0].sel == inst[1].sel)) ||
               (isMode[0] && isMode[1]);
    accept = legal & permitted & {2{!conflict}};  // a clash nacks both
  end

  ////////////////////
  // registered result, one cycle wide
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      stat     <= '0;
      clockCmd <= '0;
      alarmCmd <= '0;
      mode     <= ats21StatePkg::modeReset;
    end else begin
      for (int c = 0; c < 2; c++) begin
        stat[c] <= accept[c] ? ats21InstPkg::ack : ats21InstPkg::nack;

        clockCmd[c].valid  <= accept[c] && isClock[c];
        clockCmd[c].load   <= (op[c] == ats21InstPkg::setClock);
        clockCmd[c].index  <= ats21InstPkg::clockIndex(inst[c]);
        clockCmd[c].enable <= inst[c].flags[`ATS21_FLAG_BIT];
        clockCmd[c].rate   <= ats21StatePkg::rate_e'(
                                inst[c].flags[`ATS21_FLAG_BIT:`ATS21_RATE_LO_BIT]);
        clockCmd[c].count  <= inst[c].value;

        alarmCmd[c].valid    <= accept[c] && isAlarm[c];
        alarmCmd[c].kind     <= kind[c];
        alarmCmd[c].index    <= inst[c].sel;
        alarmCmd[c].clockSel <= inst[c].clockSel;
        alarmCmd[c].loop     <= inst[c].flags[`ATS21_FLAG_BIT];  // repeat
        alarmCmd[c].enable   <= inst[c].flags[`ATS21_FLAG_BIT];
        alarmCmd[c].value    <= inst[c].value;
      end

      // at most one setMode gets through, the other client sees old bits
      if (accept[0] && isMode[0]) begin
        mode.active      <= inst[0].sel[`ATS21_MODE_ACTIVE_BIT];
        mode.alarmAllowA <= inst[0].sel[`ATS21_MODE_ALARM_BIT];
        mode.clockAllowA <= inst[0].sel[`ATS21_MODE_CLOCK_BIT];
      end
      if (accept[1] && isMode[1]) begin
        mode.active      <= inst[1].sel[`ATS21_MODE_ACTIVE_BIT];
        mode.alarmAllowB <= inst[1].sel[`ATS21_MODE_ALARM_BIT];
        mode.clockAllowB <= inst[1].sel[`ATS21_MODE_CLOCK_BIT];
      end
    end
  end

endmodule

`default_nettype wire

// File: ats21ClockBank.sv
// counter bank, shared rate prescaler, two write ports, tick vector
`timescale 1ns/10ps
`default_nettype none
`include "ats21_consts.svh"

module ats21ClockBank (
  input  wire                                   clk_1x,
  input  wire                                   reset,
  input  wire ats21StatePkg::clockCmd_t [1:0]   clockCmd,
  input  wire ats21StatePkg::modeReg_t          mode,
  output logic [`ATS21_NUM_CLOCKS-1:0][`ATS21_COUNT_W-1:0] counts,
  output logic [`ATS21_NUM_CLOCKS-1:0]          tick
);

  typedef struct packed {
    logic                      enable;
    ats21StatePkg::rate_e      rate;
    logic [`ATS21_COUNT_W-1:0] count;
  } clockRec_t;

  clockRec_t [`ATS21_NUM_CLOCKS-1:0] clocks;
  logic [1:0]                        prescale;  // free running from reset
  logic [`ATS21_NUM_CLOCKS-1:0]      rateHit;   // rate lets it step this cycle
  logic [`ATS21_NUM_CLOCKS-1:0]      writeHit;  // a port writes it this cycle

  ////////////////////
  // tick decode
  always_comb begin
    for (int i = 0; i < `ATS21_NUM_CLOCKS; i++) begin
      case (clocks[i].rate)
        ats21StatePkg::full:    rateHit[i] = 1'b1;
        ats21StatePkg::half:    rateHit[i] = prescale[0];
        ats21StatePkg::quarter: rateHit[i] = &prescale;  // prescale == 3
        default:                rateHit[i] = 1'b0;       // stopped
      endcase
      writeHit[i] = 1'b0;
      for (int p = 0; p < 2; p++) begin
        if (clockCmd[p].valid && (clockCmd[p].index == i)) begin
          writeHit[i] = 1'b1;
        end
      end
      // write wins, so no step and no alarm match on that edge
      tick[i]   = mode.active && clocks[i].enable && rateHit[i] && !writeHit[i];
      counts[i] = clocks[i].count;
    end
  end

  ////////////////////
  // counters
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      prescale <= '0;
      clocks   <= '0;   // disabled, count zero
    end else begin
      prescale <= prescale + 2'd1;
      for (int i = 0; i < `ATS21_NUM_CLOCKS; i++) begin
        if (tick[i]) begin
          clocks[i].count <= clocks[i].count + 1'b1;  // wraps
        end
      end
      // arbiter keeps the two ports on different counters
      for (int p = 0; p < 2; p++) begin
        if (clockCmd[p].valid) begin
          if (clockCmd[p].load) begin
            clocks[clockCmd[p].index].enable <= 1'b1;  // set-clock also starts it
            clocks[clockCmd[p].index].rate   <= clockCmd[p].rate;
            clocks[clockCmd[p].index].count  <= clockCmd[p].count;
          end else begin
            clocks[clockCmd[p].index].enable <= clockCmd[p].enable;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: ats21AlarmBank.sv
// alarm and countdown timer bank, match detect, two-cycle output pulse
`timescale 1ns/10ps
`default_nettype none
`include "ats21_consts.svh"

module ats21AlarmBank (
  input  wire                                   clk_1x,
  input  wire                                   reset,
  input  wire ats21StatePkg::alarmCmd_t [1:0]   alarmCmd,
  input  wire ats21StatePkg::modeReg_t          mode,
  input  wire [`ATS21_NUM_CLOCKS-1:0][`ATS21_COUNT_W-1:0] counts,
  input  wire [`ATS21_NUM_CLOCKS-1:0]           tick,
  output logic [`ATS21_NUM_ALARMS-1:0]          data
);

  typedef struct packed {
    logic                          enable;
    logic                          loop;      // stays armed after firing
    logic [`ATS21_CLOCK_SEL_W-1:0] clockSel;  // counter it watches
    logic [`ATS21_COUNT_W-1:0]     value;     // absolute match value
  } alarmRec_t;

  alarmRec_t [`ATS21_NUM_ALARMS-1:0]                      alarms;
  logic [`ATS21_NUM_ALARMS-1:0][`ATS21_HOLD_W-1:0]        hold;  // pulse cycles left
  logic [`ATS21_NUM_ALARMS-1:0]                           fire;

  ////////////////////
  // match detect
  always_comb begin
    for (int i = 0; i < `ATS21_NUM_ALARMS; i++) begin
      // compare against the count the counter is about to take
      fire[i] = mode.active && alarms[i].enable && tick[alarms[i].clockSel] &&
                (counts[alarms[i].clockSel] + 1'b1 == alarms[i].value);
      data[i] = (hold[i] != '0);
    end
  end

  ////////////////////
  // alarm records and pulse stretch
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      alarms <= '0;   // all disarmed
      hold   <= '0;
    end else begin
      for (int i = 0; i < `ATS21_NUM_ALARMS; i++) begin
        if (fire[i]) begin
          hold[i] <= `ATS21_HOLD_W'(`ATS21_HOLD_CYCLES);
          if (!alarms[i].loop) begin
            alarms[i].enable <= 1'b0;  // one-shot
          end
        end else if (hold[i] != '0) begin
          hold[i] <= hold[i] - 1'b1;
        end
      end

      // writes after firing so a write on the same edge wins
      for (int p = 0; p < 2; p++) begin
        if (alarmCmd[p].valid) begin
          case (alarmCmd[p].kind)
            ats21StatePkg::setAlarm: begin
              alarms[alarmCmd[p].index].enable   <= 1'b1;
              alarms[alarmCmd[p].index].loop     <= alarmCmd[p].loop;
              alarms[alarmCmd[p].index].clockSel <= alarmCmd[p].clockSel;
              alarms[alarmCmd[p].index].value    <= alarmCmd[p].value;
            end
            ats21StatePkg::setTimer: begin
              alarms[alarmCmd[p].index].enable   <= 1'b1;
              alarms[alarmCmd[p].index].loop     <= 1'b0;  // timers never repeat
              alarms[alarmCmd[p].index].clockSel <= alarmCmd[p].clockSel;
              // interval turned into an absolute count, wraps with the counter
              alarms[alarmCmd[p].index].value    <=
                alarmCmd[p].value + counts[alarmCmd[p].clockSel];
            end
            default: begin
              alarms[alarmCmd[p].index].enable <= alarmCmd[p].enable;
            end
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: ats21.sv
// top level, two instruction captures, arbiter, counter bank, alarm bank
`timescale 1ns/10ps
`default_nettype none
`include "ats21_consts.svh"

module ats21 (
  input  wire                          clk_1x,
  input  wire                          reset,
  input  wire                          req,
  input  wire [`ATS21_HALF_W-1:0]      ctrlA,
  input  wire [`ATS21_HALF_W-1:0]      ctrlB,
  output wire [1:0]                    stat,   // bit 0 client A
  output wire [`ATS21_NUM_ALARMS-1:0]  data    // one per alarm
);

  ats21InstPkg::instWord_t        instA;
  ats21InstPkg::instWord_t        instB;
  logic                           presentA;
  logic                           presentB;
  ats21StatePkg::clockCmd_t [1:0] clockCmd;
  ats21StatePkg::alarmCmd_t [1:0] alarmCmd;
  ats21StatePkg::modeReg_t        mode;
  logic [`ATS21_NUM_CLOCKS-1:0][`ATS21_COUNT_W-1:0] counts;
  logic [`ATS21_NUM_CLOCKS-1:0]   tick;

  ////////////////////
  // client front ends, one per bus
  ats21InstCapture captureA (
    .clk_1x, .reset, .req, .ctrl(ctrlA), .inst(instA), .present(presentA)
  );

  ats21InstCapture captureB (
    .clk_1x, .reset, .req, .ctrl(ctrlB), .inst(instB), .present(presentB)
  );

  ////////////////////
  // decode and accept
  ats21Arbiter arbiter (
    .clk_1x, .reset,
    .instA, .presentA, .instB, .presentB,
    .clockCmd, .alarmCmd, .mode, .stat
  );

  ////////////////////
  // state
  ats21ClockBank clockBank (
    .clk_1x, .reset, .clockCmd, .mode, .counts, .tick
  );

  ats21AlarmBank alarmBank (
    .clk_1x, .reset, .alarmCmd, .mode, .counts, .tick, .data
  );

endmodule

`default_nettype wire

// File: ats21Tb.sv
// testbench for ats21, clock and reset, bus tasks, directed tests, closing report
`timescale 1ns/10ps
`default_nettype none
`include "ats21_consts.svh"

module ats21Tb;

  // longest test runs well under 100 cycles, five tests plus setup
  localparam int timeoutCycles = 3000;

  logic                         clk_1x;
  logic                         reset;
  logic                         req;
  logic [`ATS21_HALF_W-1:0]     ctrlA;
  logic [`ATS21_HALF_W-1:0]     ctrlB;
  logic [1:0]                   stat;   // bit 0 client A
  logic [`ATS21_NUM_ALARMS-1:0] data;

  int     errorCount;
  int     cycleCount;
  integer seed;

  ats21 ats21_i (
    .clk_1x, .reset, .req, .ctrlA, .ctrlB, .stat, .data
  );

  ////////////////////
  // clock and watchdog
  initial begin
    clk_1x = 1'b0;
    forever #20 clk_1x = ~clk_1x;  // 40 ns period
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge clk_1x);
      cycleCount++;
    end
    $display("timeout: the tests did not finish within %0d cycles", timeoutCycles);
    $display("*** FAILED ***");
    $finish;
  end

  ////////////////////
  // helpers
  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      errorCount++;
      $display("FAIL %0t ns: %s (got %0h, expected %0h)", $time, msg, actual, expected);
    end
  endtask

  // packs the instruction fields, op 31..29 down to value 15..0
  function automatic logic [31:0] makeInst(input logic [2:0] op, input logic [4:0] sel,
                                           input logic [3:0] flags, input logic [3:0] clockSel,
                                           input logic [15:0] value);
    return {op, sel, flags, clockSel, value};
  endfunction

  // upper half with req, lower half next cycle, returns 2 ns after the status edge
  task automatic sendInst(input logic [31:0] wordA, input logic [31:0] wordB);
    req   = 1'b1;
    ctrlA = wordA[31:16];   // all zero is a nop, no beat
    ctrlB = wordB[31:16];
    @(posedge clk_1x);
    #2;
    req   = 1'b0;           // second beat ignores req
    ctrlA = wordA[15:0];
    ctrlB = wordB[15:0];
    @(posedge clk_1x);
    #2;
    ctrlA = '0;
    ctrlB = '0;
  endtask

  task automatic expectStat(input logic [1:0] expected, input string what);
    check(stat, expected, what);  // registered, stable for this whole cycle
  endtask

  // counts edges until the bit rises, then checks a two-cycle pulse and quiet after
  task automatic waitAlarm(input int bitIdx, input int earliest, input int latest,
                           input int quiet, input string what);
    int   n;
    logic rose;
    n    = 0;
    rose = 1'b0;
    while (!rose && n < latest) begin
      @(posedge clk_1x);
      #2;
      n++;
      rose = data[bitIdx];
    end
    check(rose, 1'b1, {what, ": data bit never rose"});
    check((n >= earliest) && (n <= latest), 1'b1, {what, ": rise edge out of window"});
    @(posedge clk_1x);
    #2;
    check(data[bitIdx], 1'b1, {what, ": second pulse cycle"});
    repeat (quiet + 1) begin
      @(posedge clk_1x);
      #2;
      check(data[bitIdx], 1'b0, {what, ": low after pulse"});
    end
  endtask

  ////////////////////
  // directed tests
  task automatic fullRateAlarm();
    int          c;
    int          a;
    logic [15:0] base;
    c    = $unsigned($random(seed)) % `ATS21_NUM_CLOCKS;
    a    = $unsigned($random(seed)) % `ATS21_NUM_ALARMS;
    base = $random(seed) & 16'h3fff;  // keep clear of wrap
    // load lands one edge after the return, alarm due 10 ticks later
    sendInst(makeInst(ats21InstPkg::setClock, {c[3:0], 1'b0}, 4'b0000, 4'h0, base),
             makeInst(ats21InstPkg::setAlarm, a[4:0], 4'b0000, c[3:0], base + 16'd10));
    expectStat(2'b11, "full-rate load and alarm");
    waitAlarm(a, 11, 11, 8, "full-rate alarm");
  endtask

  task automatic timerAndRepeat();
    int          c;
    int          a;
    int          interval;
    logic [15:0] base;
    c        = $unsigned($random(seed)) % `ATS21_NUM_CLOCKS;
    a        = $unsigned($random(seed)) % `ATS21_NUM_ALARMS;
    base     = $random(seed) & 16'h3fff;
    interval = 5 + $unsigned($random(seed)) % 8;
    sendInst(makeInst(ats21InstPkg::setClock, {c[3:0], 1'b0}, 4'b0000, 4'h0, base), '0);
    expectStat(2'b01, "timer counter load");
    // timer adds the count seen just before its write edge
    sendInst(makeInst(ats21InstPkg::setTimer, a[4:0], 4'b0000, c[3:0], interval[15:0]), '0);
    expectStat(2'b01, "timer write");
    waitAlarm(a, interval, interval, 4, "countdown timer");

    // repeating alarm, reload below the value and it fires again
    c    = $unsigned($random(seed)) % `ATS21_NUM_CLOCKS;
    a    = $unsigned($random(seed)) % `ATS21_NUM_ALARMS;
    sendInst(makeInst(ats21InstPkg::setClock, {c[3:0], 1'b0}, 4'b0000, 4'h0, base),
             makeInst(ats21InstPkg::setAlarm, a[4:0], 4'b1000, c[3:0], base + 16'd6));
    expectStat(2'b11, "repeat alarm setup");
    waitAlarm(a, 7, 7, 2, "repeat alarm first");
    sendInst(makeInst(ats21InstPkg::setClock, {c[3:0], 1'b0}, 4'b0000, 4'h0, base), '0);
    expectStat(2'b01, "repeat counter reload");
    waitAlarm(a, 7, 7, 2, "repeat alarm second");

    // quarter rate, flags 10 on the rate bits
    c    = $unsigned($random(seed)) % `ATS21_NUM_CLOCKS;
    a    = $unsigned($random(seed)) % `ATS21_NUM_ALARMS;
    sendInst(makeInst(ats21InstPkg::setClock, {c[3:0], 1'b0}, 4'b1000, 4'h0, base),
             makeInst(ats21InstPkg::setAlarm, a[4:0], 4'b0000, c[3:0], base + 16'd6));
    expectStat(2'b11, "quarter-rate setup");
    // six ticks four edges apart, the first at least one edge after the load
    waitAlarm(a, 4 * 5 + 2, 4 * 6 + 4, 2, "quarter-rate alarm");
  endtask

  task automatic conflictAndRange();
    int a;
    int c;
    a = $unsigned($random(seed)) % `ATS21_NUM_ALARMS;
    c = $unsigned($random(seed)) % `ATS21_NUM_CLOCKS;
    sendInst(makeInst(ats21InstPkg::setAlarm, a[4:0], 4'b0000, c[3:0], 16'h0100),
             makeInst(ats21InstPkg::setAlarm, a[4:0], 4'b0000, c[3:0], 16'h0200));
    expectStat(2'b00, "same alarm from both clients");
    @(posedge clk_1x);
    #2;
    check(stat, 2'b00, "stat back to nack");
    sendInst(makeInst(ats21InstPkg::setAlarm, a[4:0], 4'b0000, c[3:0], 16'h0100),
             makeInst(ats21InstPkg::setAlarm, 5'((a + 1) % 24), 4'b0000, c[3:0], 16'h0200));
    expectStat(2'b11, "different alarms");
    // sel 24..31 is past the bank
    sendInst(makeInst(ats21InstPkg::setAlarm, 5'(24 + $unsigned($random(seed)) % 8),
                      4'b0000, c[3:0], 16'h0100), '0);
    expectStat(2'b00, "alarm index out of range");
    sendInst(makeInst(3'b100, a[4:0], 4'b0000, c[3:0], 16'h0100), '0);
    expectStat(2'b00, "illegal opcode");
  endtask

  task automatic clientPermissions();
    int          c;
    int          a;
    int          b;
    logic [15:0] base;
    c    = $unsigned($random(seed)) % `ATS21_NUM_CLOCKS;
    a    = $unsigned($random(seed)) % `ATS21_NUM_ALARMS;
    b    = (a + 1) % `ATS21_NUM_ALARMS;
    base = $random(seed) & 16'h3fff;
    // sel 10010 = active, no alarm change, clock change
    sendInst(makeInst(ats21InstPkg::setMode, 5'b10010, 4'b0000, 4'h0, 16'h0), '0);
    expectStat(2'b01, "client A drops alarm permission");
    sendInst(makeInst(ats21InstPkg::setClock, {c[3:0], 1'b0}, 4'b0000, 4'h0, base), '0);
    expectStat(2'b01, "clock load still allowed")
;
    // counter reads base+2 on the arming edge, A due 18 edges later, B 28
    sendInst(makeInst(ats21InstPkg::setAlarm, a[4:0], 4'b0000, c[3:0], base + 16'd20),
             makeInst(ats21InstPkg::setAlarm, b[4:0], 4'b0000, c[3:0], base + 16'd30));
    expectStat(2'b10, "A refused, B accepted");
    repeat (20) begin  // past the edge the refused alarm would fire on
      @(posedge clk_1x);
      #2;
      check(data[a], 1'b0, "refused alarm stays low");
    end
    waitAlarm(b, 9, 9, 2, "client B alarm");  // 29 edges after the status
    sendInst(makeInst(ats21InstPkg::setMode, 5'b11010, 4'b0000, 4'h0, 16'h0), '0);
    expectStat(2'b01, "client A permissions restored");
  endtask

  task automatic inactiveDevice();
    int          c;
    int          a;
    logic [15:0] base;
    c    = $unsigned($random(seed)) % `ATS21_NUM_CLOCKS;
    a    = $unsigned($random(seed)) % `ATS21_NUM_ALARMS;
    base = $random(seed) & 16'h3fff;
    sendInst(makeInst(ats21InstPkg::setClock, {c[3:0], 1'b0}, 4'b0000, 4'h0, base),
             makeInst(ats21InstPkg::setAlarm, a[4:0], 4'b0000, c[3:0], base + 16'd20));
    expectStat(2'b11, "inactive test setup");
    // counter steps once more before the mode write lands, freezes at base+1
    sendInst(makeInst(ats21InstPkg::setMode, 5'b01010, 4'b0000, 4'h0, 16'h0), '0);
    expectStat(2'b01, "device set inactive");
    repeat (30) begin
      @(posedge clk_1x);
      #2;
      check(data[a], 1'b0, "alarm quiet while inactive");
    end
    sendInst(makeInst(ats21InstPkg::setMode, 5'b11010, 4'b0000, 4'h0, 16'h0), '0);
    expectStat(2'b01, "device active again");
    waitAlarm(a, 19, 19, 2, "alarm after reactivation");  // base+1 up to base+20
  endtask

  ////////////////////
  // main sequence
  initial begin
    seed       = 20135;
    errorCount = 0;
    reset      = 1'b1;
    req        = 1'b0;
    ctrlA      = '0;
    ctrlB      = '0;
    repeat (4) @(posedge clk_1x);
    #2;
    reset = 1'b0;
    check(stat, 2'b00, "stat after reset");
    check(data, '0, "data after reset");

    fullRateAlarm();
    timerAndRepeat();
    conflictAndRange();
    clientPermissions();
    inactiveDevice();

    repeat (4) @(posedge clk_1x);
    $display("ats21Tb finished with %0d errors", errorCount);
    if (errorCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ats21.f
+incdir+.
ats21InstPkg.sv
ats21StatePkg.sv
ats21InstCapture.sv
ats21Arbiter.sv
ats21ClockBank.sv
ats21AlarmBank.sv
ats21.sv
ats21Tb.sv
